/* hw/alu_params.svh */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

////////////////////
// Datapath sizes
////////////////////

// Integer register width
`define XLEN 64

// Architectural register count, x0 included
`define NUM_REGS 32

// Register index width
`define REG_AW 5

////////////////////
// Opcodes
////////////////////

// Register-register arithmetic, M-extension included
`define OPC_OP 7'b0110011

// Register-immediate arithmetic
`define OPC_OP_IMM 7'b0010011

`endif

/* hw/alu_pkg.sv */
`default_nettype none

`include "alu_params.svh"

package alu_pkg;

    ////////////////////
    // Instruction word
    ////////////////////

    // R-type layout
    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } r_type_t;

    // I-type layout, imm overlays funct7 and rs2
    typedef struct packed {
        logic [11:0]        imm;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r_fields;
        i_type_t i_fields;
    } instr_t;

    ////////////////////
    // Op select
    ////////////////////

    // One-hot, op_add is bit 0 and op_remu is bit 14
    typedef struct packed {
        logic op_remu;
        logic op_rem;
        logic op_divu;
        logic op_div;
        logic op_mul;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_and;
        logic op_or;
        logic op_xor;
        logic op_sltu;
        logic op_slt;
        logic op_sub;
        logic op_add;
    } alu_op_t;

    ////////////////////
    // Stage structs
    ////////////////////

    // Decoder to execute unit
    typedef struct packed {
        logic               valid;
        alu_op_t            op_sel;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic               use_rs2;
        logic [`XLEN-1:0]   op1;
        logic [`XLEN-1:0]   op2;
    } issue_t;

    // Execute unit to register file and outputs
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } wb_t;

endpackage

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu (
    input  logic [`XLEN-1:0] op1,
    input  logic [`XLEN-1:0] op2,
    input  alu_pkg::alu_op_t op_sel,
    output logic [`XLEN-1:0] result
);

    localparam int SHW = $clog2(`XLEN);

    function automatic logic [`XLEN-1:0] bit_rev(input logic [`XLEN-1:0] v);
        logic [`XLEN-1:0] r;
        for (int i = 0; i < `XLEN; i++) begin
            r[i] = v[`XLEN-1-i];
        end
        return r;
    endfunction

    logic             inv_op2;
    logic [`XLEN-1:0] adder_b;
    logic [`XLEN-1:0] sum;
    logic             cout;
    logic [`XLEN-1:0] slt_result;
    logic [`XLEN-1:0] sltu_result;
    logic [SHW-1:0]   shamt;
    logic [`XLEN-1:0] shift_in;
    logic [`XLEN-1:0] shift_out;
    logic [`XLEN-1:0] sra_mask;
    logic [`XLEN-1:0] sll_result;
    logic [`XLEN-1:0] sra_result;
    logic [`XLEN-1:0] mul_result;
    logic             div_zero;
    logic             div_ovf;
    logic [`XLEN-1:0] sdivisor;
    logic [`XLEN-1:0] udivisor;
    logic [`XLEN-1:0] sdiv_quot;
    logic [`XLEN-1:0] sdiv_rem;
    logic [`XLEN-1:0] div_result;
    logic [`XLEN-1:0] divu_result;
    logic [`XLEN-1:0] rem_result;
    logic [`XLEN-1:0] remu_result;

    ////////////////////
    // Adder
    ////////////////////

    // Subtract as op1 + ~op2 + 1 for sub and both compares
    assign inv_op2 = op_sel.op_sub | op_sel.op_slt | op_sel.op_sltu;
    assign adder_b = inv_op2 ? ~op2 : op2;
    assign {cout, sum} = {1'b0, op1} + {1'b0, adder_b} + {{`XLEN{1'b0}}, inv_op2};

    // Less when only op1 is negative or equal signs give a negative difference
    assign slt_result  = {{(`XLEN-1){1'b0}},
                          (op1[`XLEN-1] & ~op2[`XLEN-1]) |
                          (~(op1[`XLEN-1] ^ op2[`XLEN-1]) & sum[`XLEN-1])};
    // No carry out means a borrow
    assign sltu_result = {{(`XLEN-1){1'b0}}, ~cout};

    ////////////////////
    // Shifter
    ////////////////////

    // Left shift reuses the right shifter on reversed bits
    assign shamt      = op2[SHW-1:0];
    assign shift_in   = op_sel.op_sll ? bit_rev(op1) : op1;
    assign shift_out  = shift_in >> shamt;
    assign sll_result = bit_rev(shift_out);

    // Fill vacated upper bits with the sign
    assign sra_mask   = ~({`XLEN{1'b1}} >> shamt);
    assign sra_result = ({`XLEN{shift_in[`XLEN-1]}} & sra_mask) | shift_out;

    ////////////////////
    // Multiply and divide
    ////////////////////

    assign mul_result = $signed(op1) * $signed(op2);

    assign div_zero = (op2 == '0);
    assign div_ovf  = (op1 == {1'b1, {(`XLEN-1){1'b0}}}) && (op2 == '1);

    // Dividing by one on overflow yields dividend and zero remainder
    assign sdivisor = (div_zero | div_ovf) ? {{(`XLEN-1){1'b0}}, 1'b1} : op2;
    assign udivisor = div_zero ? {{(`XLEN-1){1'b0}}, 1'b1} : op2;

    assign sdiv_quot = $signed(op1) / $signed(sdivisor);
    assign sdiv_rem  = $signed(op1) % $signed(sdivisor);

    assign div_result  = div_zero ? '1 : sdiv_quot;
    assign rem_result  = div_zero ? op1 : sdiv_rem;
    assign divu_result = div_zero ? '1 : op1 / udivisor;
    assign remu_result = div_zero ? op1 : op1 % udivisor;

    // One-hot AND-OR result select
    assign result = ({`XLEN{op_sel.op_add | op_sel.op_sub}} & sum)
                  | ({`XLEN{op_sel.op_slt}}  & slt_result)
                  | ({`XLEN{op_sel.op_sltu}} & sltu_result)
                  | ({`XLEN{op_sel.op_xor}}  & (op1 ^ op2))
                  | ({`XLEN{op_sel.op_or}}   & (op1 | op2))
                  | ({`XLEN{op_sel.op_and}}  & (op1 & op2))
                  | ({`XLEN{op_sel.op_sll}}  & sll_result)
                  | ({`XLEN{op_sel.op_srl}}  & shift_out)
                  | ({`XLEN{op_sel.op_sra}}  & sra_result)
                  | ({`XLEN{op_sel.op_mul}}  & mul_result)
                  | ({`XLEN{op_sel.op_div}}  & div_result)
                  | ({`XLEN{op_sel.op_divu}} & divu_result)
                  | ({`XLEN{op_sel.op_rem}}  & rem_result)
                  | ({`XLEN{op_sel.op_remu}} & remu_result);

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module instr_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  alu_pkg::instr_t     instr,
    output logic [`REG_AW-1:0]  rs1_addr,
    output logic [`REG_AW-1:0]  rs2_addr,
    input  logic [`XLEN-1:0]    rs1_data,
    input  logic [`XLEN-1:0]    rs2_data,
    output alu_pkg::issue_t     issue,
    output logic                illegal
);

    import alu_pkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [5:0]       funct6;
    logic [`XLEN-1:0] imm_ext;
    alu_op_t          op_sel;
    logic             use_rs2;
    logic             bad;
    issue_t           issue_next;

    // Same word, read through both views
    assign opcode  = instr.r_fields.opcode;
    assign funct3  = instr.r_fields.funct3;
    assign funct7  = instr.r_fields.funct7;
    assign funct6  = instr.i_fields.imm[11:6];
    assign imm_ext = {{(`XLEN-12){instr.i_fields.imm[11]}}, instr.i_fields.imm};

    assign rs1_addr = instr.r_fields.rs1;
    assign rs2_addr = instr.r_fields.rs2;

    ////////////////////
    // Op decode
    ////////////////////

    always_comb begin
        op_sel  = '0;
        use_rs2 = 1'b0;
        bad     = 1'b0;
        case (opcode)
            `OPC_OP: begin
                use_rs2 = 1'b1;
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000:  op_sel.op_add  = 1'b1;
                            3'b001:  op_sel.op_sll  = 1'b1;
                            3'b010:  op_sel.op_slt  = 1'b1;
                            3'b011:  op_sel.op_sltu = 1'b1;
                            3'b100:  op_sel.op_xor  = 1'b1;
                            3'b101:  op_sel.op_srl  = 1'b1;
                            3'b110:  op_sel.op_or   = 1'b1;
                            default: op_sel.op_and  = 1'b1;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000:  op_sel.op_sub = 1'b1;
                            3'b101:  op_sel.op_sra = 1'b1;
                            default: bad = 1'b1;
                        endcase
                    end
                    7'b0000001: begin
                        // mulh variants are not supported
                        case (funct3)
                            3'b000:  op_sel.op_mul  = 1'b1;
                            3'b100:  op_sel.op_div  = 1'b1;
                            3'b101:  op_sel.op_divu = 1'b1;
                            3'b110:  op_sel.op_rem  = 1'b1;
                            3'b111:  op_sel.op_remu = 1'b1;
                            default: bad = 1'b1;
                        endcase
                    end
                    default: bad = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                case (funct3)
                    3'b000: op_sel.op_add  = 1'b1;
                    3'b010: op_sel.op_slt  = 1'b1;
                    3'b011: op_sel.op_sltu = 1'b1;
                    3'b100: op_sel.op_xor  = 1'b1;
                    3'b110: op_sel.op_or   = 1'b1;
                    3'b111: op_sel.op_and  = 1'b1;
                    // Shift immediates, imm[5:0] is shamt
                    3'b001: begin
                        if (funct6 == 6'b000000) op_sel.op_sll = 1'b1;
                        else bad = 1'b1;
                    end
                    default: begin
                        if (funct6 == 6'b000000) op_sel.op_srl = 1'b1;
                        else if (funct6 == 6'b010000) op_sel.op_sra = 1'b1;
                        else bad = 1'b1;
                    end
                endcase
            end
            default: bad = 1'b1;
        endcase
    end

    ////////////////////
    // Issue register
    ////////////////////

    always_comb begin
        issue_next.valid   = instr_valid & ~bad;
        issue_next.op_sel  = op_sel;
        issue_next.rd      = instr.r_fields.rd;
        issue_next.rs1     = rs1_addr;
        issue_next.rs2     = rs2_addr;
        issue_next.use_rs2 = use_rs2;
        issue_next.op1     = rs1_data;
        issue_next.op2     = use_rs2 ? rs2_data : imm_ext;
    end

    always_ff @(posedge clk) begin
        issue   <= issue_next;
        illegal <= instr_valid & bad;
        if (rst) begin
            issue.valid <= 1'b0;
            illegal     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] rs1_addr,
    input  logic [`REG_AW-1:0] rs2_addr,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  alu_pkg::wb_t       wb
);

    // x1 to x31 only, x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    // The write landing this edge is forwarded, so an instruction
    // two slots behind the producer still sees the new value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) data = '0;
        else if (wb.valid && (wb.rd == addr)) data = wb.data;
        else data = regs[addr];
        return data;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module exec_unit (
    input  logic            clk,
    input  logic            rst,
    input  alu_pkg::issue_t issue,
    output alu_pkg::wb_t    wb
);

    import alu_pkg::*;

    logic             hit_rs1;
    logic             hit_rs2;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] alu_result;
    wb_t              wb_next;

    ////////////////////
    // Bypass
    ////////////////////

    // Previous result is held in wb but not yet in the register file
    assign hit_rs1 = wb.valid && (wb.rd != '0) && (wb.rd == issue.rs1);
    // Immediate forms carry no rs2
    assign hit_rs2 = wb.valid && (wb.rd != '0) && issue.use_rs2 && (wb.rd == issue.rs2);

    assign op1 = hit_rs1 ? wb.data : issue.op1;
    assign op2 = hit_rs2 ? wb.data : issue.op2;

    alu u_alu (
        .op1    (op1),
        .op2    (op2),
        .op_sel (issue.op_sel),
        .result (alu_result)
    );

    ////////////////////
    // Result register
    ////////////////////

    always_comb begin
        wb_next.valid = issue.valid;
        wb_next.rd    = issue.rd;
        wb_next.data  = alu_result;
    end

    always_ff @(posedge clk) begin
        wb <= wb_next;
        if (rst) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/alu_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  alu_pkg::instr_t    instr,
    output logic               result_valid,
    output logic [`REG_AW-1:0] result_rd,
    output logic [`XLEN-1:0]   result,
    output logic               illegal
);

    import alu_pkg::*;

    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    issue_t             issue;
    wb_t                wb;

    instr_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .issue       (issue),
        .illegal     (illegal)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    exec_unit u_exec (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .wb    (wb)
    );

    // Writeback doubles as the result port
    assign result_valid = wb.valid;
    assign result_rd    = wb.rd;
    assign result       = wb.data;

endmodule

`default_nettype wire

/* testbench/alu_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_core_assert (
    input logic               clk,
    input logic               rst,
    input logic               instr_valid,
    input logic               result_valid,
    input logic [`REG_AW-1:0] result_rd,
    input logic [`XLEN-1:0]   result,
    input logic               illegal
);

    ////////////////////
    // Port protocol
    ////////////////////

    // Fixed latency of two for an accepted instruction
    a_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(illegal) |-> (result_valid == $past(instr_valid, 2)))
        else $error("result_valid does not match instr_valid two cycles earlier");

    // A rejected instruction never writes back
    a_exclusive: assert property (@(posedge clk) disable iff (rst)
        $past(illegal) |-> !result_valid)
        else $error("result_valid raised for an instruction flagged illegal");

    a_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        (result_valid && (result != '0)) |-> (result_rd != '0))
        else $error("nonzero result written back to x0");

endmodule

bind alu_core_top alu_core_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result       (result),
    .illegal      (illegal)
);

`default_nettype wire

/* testbench/alu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu_core_tb;

    import alu_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_RAND     = 32;

    typedef logic [`XLEN-1:0] xword_t;

    localparam xword_t ONES = '1;
    localparam xword_t NEG3 = 64'hFFFF_FFFF_FFFF_FFFD;
    localparam xword_t MSB  = 64'h8000_0000_0000_0000;

    // One row of the directed table
    typedef struct packed {
        logic [31:0] word;
        logic        bad;
        xword_t      data;
    } test_t;

    // Expected response of one issue slot
    typedef struct packed {
        logic               valid;
        logic               illegal;
        logic [`REG_AW-1:0] rd;
        xword_t             data;
    } slot_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    instr_t             instr;
    logic               result_valid;
    logic [`REG_AW-1:0] result_rd;
    xword_t             result;
    logic               illegal;

    test_t       tests[$];
    string       names[$];
    xword_t      shadow [0:`NUM_REGS-1];
    slot_t       stage1;
    slot_t       stage2;
    string       name1;
    string       name2;
    logic [31:0] lfsr;
    int          cycles = 0;
    int          cycle_limit = 0;

    alu_core_top uut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result       (result),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("=== FAIL ===");
            $fatal(1, "Timeout after %0d cycles, the test sequence did not finish", cycles);
        end
    end

    ////////////////////
    // Encoders
    ////////////////////

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic xword_t sext12(input logic [11:0] imm);
        return {{(`XLEN-12){imm[11]}}, imm};
    endfunction

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic compare(input string name, input xword_t expected, input xword_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Output check failed for %s", name);
        end
    endtask

    // Result belongs to two slots back, illegal to one slot back
    task automatic check_slots();
        compare({name2, " result_valid"}, xword_t'(stage2.valid), xword_t'(result_valid));
        if (stage2.valid) begin
            compare({name2, " result_rd"}, xword_t'(stage2.rd), xword_t'(result_rd));
            compare({name2, " result"}, stage2.data, result);
        end
        compare({name1, " illegal"}, xword_t'(stage1.illegal), xword_t'(illegal));
    endtask

    task automatic drive_slot(input string name, input logic valid, input test_t t);
        @(negedge clk);
        check_slots();
        stage2         = stage1;
        name2          = name1;
        stage1.valid   = valid & ~t.bad;
        stage1.illegal = valid & t.bad;
        stage1.rd      = t.word[11:7];
        stage1.data    = t.data;
        name1          = name;
        instr_valid    = valid;
        instr          = t.word;
    endtask

    task automatic add_test(input string name, input logic [31:0] word, input logic bad,
                            input xword_t data);
        names.push_back(name);
        tests.push_back({word, bad, data});
    endtask

    ////////////////////
    // Directed table
    ////////////////////

    task automatic load_table();
        // Registers still hold their reset value
        add_test("add_zero",   r_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd1), 1'b0, '0);
        add_test("addi_pos",   i_word(12'h005, 5'd0, 3'b000, 5'd1), 1'b0, 64'd5);
        add_test("addi_neg",   i_word(12'hFFD, 5'd0, 3'b000, 5'd2), 1'b0, NEG3);
        // x1 from two slots back, x2 from the bypass
        add_test("add_dep",    r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, 64'd2);
        add_test("sub",        r_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 1'b0, NEG3);
        add_test("slt",        r_word(7'h00, 5'd3, 5'd4, 3'b010, 5'd5), 1'b0, 64'd1);
        add_test("addi_ones",  i_word(12'hFFF, 5'd0, 3'b000, 5'd7), 1'b0, ONES);
        add_test("sltu_ones",  r_word(7'h00, 5'd7, 5'd4, 3'b011, 5'd8), 1'b0, 64'd1);
        add_test("sltiu_ones", i_word(12'hFFF, 5'd7, 3'b011, 5'd9), 1'b0, '0);
        add_test("xor",        r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), 1'b0,
                 64'hFFFF_FFFF_FFFF_FFF8);
        add_test("or",         r_word(7'h00, 5'd3, 5'd1, 3'b110, 5'd11), 1'b0, 64'd7);
        add_test("and",        r_word(7'h00, 5'd4, 5'd11, 3'b111, 5'd12), 1'b0, 64'd5);
        add_test("xori",       i_word(12'h0F0, 5'd1, 3'b100, 5'd13), 1'b0, 64'hF5);
        add_test("ori_neg",    i_word(12'hFF0, 5'd1, 3'b110, 5'd14), 1'b0,
                 64'hFFFF_FFFF_FFFF_FFF5);
        add_test("andi",       i_word(12'h0FF, 5'd14, 3'b111, 5'd15), 1'b0, 64'hF5);
        add_test("slli_1",     i_word(12'h001, 5'd1, 3'b001, 5'd17), 1'b0, 64'hA);
        add_test("slli_63",    i_word(12'h03F, 5'd1, 3'b001, 5'd18), 1'b0, MSB);
        add_test("srli_63",    i_word(12'h03F, 5'd18, 3'b101, 5'd19), 1'b0, 64'd1);
        add_test("srai_63",    i_word(12'h43F, 5'd18, 3'b101, 5'd20), 1'b0, ONES);
        add_test("srai_1",     i_word(12'h401, 5'd18, 3'b101, 5'd21), 1'b0,
                 64'hC000_0000_0000_0000);
        add_test("srl",        r_word(7'h00, 5'd19, 5'd18, 3'b101, 5'd22), 1'b0,
                 64'h4000_0000_0000_0000);
        add_test("sra_0",      r_word(7'h20, 5'd0, 5'd4, 3'b101, 5'd23), 1'b0, NEG3);
        add_test("sll",        r_word(7'h00, 5'd19, 5'd7, 3'b001, 5'd24), 1'b0,
                 64'hFFFF_FFFF_FFFF_FFFE);
        add_test("mul",        r_word(7'h01, 5'd3, 5'd4, 3'b000, 5'd25), 1'b0,
                 64'hFFFF_FFFF_FFFF_FFFA);
        // Most negative value over minus one
        add_test("div_ovf",    r_word(7'h01, 5'd20, 5'd18, 3'b100, 5'd26), 1'b0, MSB);
        add_test("rem_ovf",    r_word(7'h01, 5'd20, 5'd18, 3'b110, 5'd27), 1'b0, '0);
        add_test("div_zero",   r_word(7'h01, 5'd0, 5'd1, 3'b100, 5'd28), 1'b0, ONES);
        add_test("divu_zero",  r_word(7'h01, 5'd0, 5'd1, 3'b101, 5'd29), 1'b0, ONES);
        add_test("rem_zero",   r_word(7'h01, 5'd0, 5'd4, 3'b110, 5'd30), 1'b0, NEG3);
        add_test("remu_zero",  r_word(7'h01, 5'd0, 5'd1, 3'b111, 5'd31), 1'b0, 64'd5);
        add_test("div",        r_word(7'h01, 5'd3, 5'd4, 3'b100, 5'd25), 1'b0, ONES);
        add_test("rem",        r_word(7'h01, 5'd3, 5'd4, 3'b110, 5'd26), 1'b0, ONES);
        add_test("divu",       r_word(7'h01, 5'd3, 5'd11, 3'b101, 5'd27), 1'b0, 64'd3);
        add_test("remu",       r_word(7'h01, 5'd3, 5'd11, 3'b111, 5'd28), 1'b0, 64'd1);
        add_test("x0_write",   r_word(7'h20, 5'd11, 5'd11, 3'b000, 5'd0), 1'b0, '0);
        add_test("x0_read",    r_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd29), 1'b0, 64'd5);
        // Unsupported encodings, all aimed at x5
        add_test("ill_opcode", 32'h0000_2283, 1'b1, '0);
        add_test("ill_funct7", r_word(7'h20, 5'd3, 5'd1, 3'b001, 5'd5), 1'b1, '0);
        add_test("ill_mulhsu", r_word(7'h01, 5'd3, 5'd1, 3'b010, 5'd5), 1'b1, '0);
        add_test("ill_srai",   i_word(12'h801, 5'd1, 3'b101, 5'd5), 1'b1, '0);
        add_test("after_ill",  r_word(7'h00, 5'd0, 5'd5, 3'b000, 5'd30), 1'b0, 64'd1);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [31:0]        bits;
        logic [1:0]         kind;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [11:0]        imm;
        logic [31:0]        word;
        xword_t             data;

        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        stage1      = '0;
        stage2      = '0;
        name1       = "reset";
        name2       = "reset";
        lfsr        = 32'd81581;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end

        load_table();
        cycle_limit = 2 * (tests.size() + NUM_RAND) + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Back to back, no idle slots
        foreach (tests[i]) begin
            drive_slot(names[i], 1'b1, tests[i]);
            rd = tests[i].word[11:7];
            if (!tests[i].bad && rd != '0) begin
                shadow[rd] = tests[i].data;
            end
        end

        // Random addi, xori, or, xor chains on top of the table state
        for (int i = 0; i < NUM_RAND; i++) begin
            bits = take_bits(2);
            kind = bits[1:0];
            bits = take_bits(5);
            rd   = (bits[4:0] == '0) ? 5'd1 : bits[4:0];
            bits = take_bits(5);
            rs1  = bits[4:0];
            bits = take_bits(5);
            rs2  = bits[4:0];
            bits = take_bits(12);
            imm  = bits[11:0];
            case (kind)
                2'd0: begin
                    word = i_word(imm, rs1, 3'b000, rd);
                    data = shadow[rs1] + sext12(imm);
                end
                2'd1: begin
                    word = i_word(imm, rs1, 3'b100, rd);
                    data = shadow[rs1] ^ sext12(imm);
                end
                2'd2: begin
                    word = r_word(7'h00, rs2, rs1, 3'b110, rd);
                    data = shadow[rs1] | shadow[rs2];
                end
                default: begin
                    word = r_word(7'h00, rs2, rs1, 3'b100, rd);
                    data = shadow[rs1] ^ shadow[rs2];
                end
            endcase
            shadow[rd] = data;
            drive_slot($sformatf("rand_%0d", i), 1'b1, {word, 1'b0, data});
        end

        // Let the last two slots drain
        drive_slot("drain", 1'b0, '0);
        drive_slot("drain", 1'b0, '0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/alu_core_top.sv
testbench/alu_core_assert.sv
testbench/alu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module alu_core_tb \
    -f src.f \
    -o alu_core_sim

./obj_dir/alu_core_sim
